// File: logic/ex_pkg.sv
package ex_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int xlen      = 32;
    localparam int rob_tag_w = 5;

    // alu function codes
    // the four multiply codes are routed to the booth unit
    typedef enum logic [4:0] {
        alu_add    = 5'h00,
        alu_sub    = 5'h01,
        alu_slt    = 5'h02,
        alu_sltu   = 5'h03,
        alu_and    = 5'h04,
        alu_or     = 5'h05,
        alu_xor    = 5'h06,
        alu_sll    = 5'h07,
        alu_srl    = 5'h08,
        alu_sra    = 5'h09,
        alu_mul    = 5'h0a,
        alu_mulh   = 5'h0b,
        alu_mulhsu = 5'h0c,
        alu_mulhu  = 5'h0d
    } alu_func_e;

    // operand a sources
    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_npc  = 2'h1,
        opa_is_pc   = 2'h2,
        opa_is_zero = 2'h3
    } opa_sel_e;

    // operand b sources, codes 6 and 7 unused
    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_sel_e;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                 issue_valid;
        logic [rob_tag_w-1:0] rob_tag;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      npc;
        logic [31:0]          inst;
        logic [xlen-1:0]      opa;
        logic [xlen-1:0]      opb;
        opa_sel_e             opa_select;
        opb_sel_e             opb_select;
        alu_func_e            alu_func;
        logic                 rd_mem;
        logic                 wr_mem;
        logic                 cond_branch;
        logic                 uncond_branch;
    } is_ex_packet_t;

    // towards the common data bus
    typedef struct packed {
        logic                 valid;
        logic [rob_tag_w-1:0] rob_tag;
        logic [xlen-1:0]      value;
        logic                 take_branch;
    } ex_cp_packet_t;

    // effective address of a load or store
    typedef struct packed {
        logic                 valid;
        logic [rob_tag_w-1:0] tag;
        logic [xlen-1:0]      addr;
    } priv_addr_packet_t;

    //////////////////////////////////////////////////
    // rv32 immediates, all sign extended
    //////////////////////////////////////////////////
    function automatic logic [xlen-1:0] i_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [xlen-1:0] s_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    // branch offset, bit 0 always zero
    function automatic logic [xlen-1:0] b_imm(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [xlen-1:0] u_imm(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    // jal offset
    function automatic logic [xlen-1:0] j_imm(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic logic is_mul_func(input alu_func_e func);
        return func inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};
    endfunction

endpackage

// File: logic/operand_select.sv
module operand_select import ex_pkg::*; (
    input  is_ex_packet_t   issue_pkt,
    output logic [xlen-1:0] opa_val,
    output logic [xlen-1:0] opb_val
);

    // operand a mux
    always_comb begin
        case (issue_pkt.opa_select)
            opa_is_rs1:  opa_val = issue_pkt.opa;
            opa_is_npc:  opa_val = issue_pkt.npc;
            opa_is_pc:   opa_val = issue_pkt.pc;
            opa_is_zero: opa_val = '0;
            // filler, easy to spot in a waveform
            default:     opa_val = 32'hdead_face;
        endcase
    end

    // operand b mux
    // immediates decoded straight from the instruction word
    always_comb begin
        case (issue_pkt.opb_select)
            opb_is_rs2:   opb_val = issue_pkt.opb;
            opb_is_i_imm: opb_val = i_imm(issue_pkt.inst);
            opb_is_s_imm: opb_val = s_imm(issue_pkt.inst);
            opb_is_b_imm: opb_val = b_imm(issue_pkt.inst);
            opb_is_u_imm: opb_val = u_imm(issue_pkt.inst);
            opb_is_j_imm: opb_val = j_imm(issue_pkt.inst);
            default:      opb_val = 32'hface_feed;
        endcase
    end

    // decode upstream must never issue a packet with a bad select
    always_comb begin
        if (issue_pkt.issue_valid) begin
            assert (!$isunknown(issue_pkt.opa_select) &&
                    issue_pkt.opb_select inside {opb_is_rs2, opb_is_i_imm, opb_is_s_imm,
                                                 opb_is_b_imm, opb_is_u_imm, opb_is_j_imm})
                else $error("operand select out of range on issued packet");
        end
    end

endmodule

// File: logic/ex_alu.sv
module ex_alu import ex_pkg::*; (
    input  logic [xlen-1:0] opa,
    input  logic [xlen-1:0] opb,
    input  alu_func_e       func,
    output logic [xlen-1:0] result
);

    logic signed [xlen-1:0] opa_s;
    logic signed [xlen-1:0] opb_s;
    logic [4:0]             shamt;

    // signed views for slt and sra
    assign opa_s = opa;
    assign opb_s = opb;

    // rv32 uses only the low five bits
    assign shamt = opb[4:0];

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_slt:  result = {{(xlen-1){1'b0}}, opa_s < opb_s};
            alu_sltu: result = {{(xlen-1){1'b0}}, opa < opb};
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result = opa_s >>> shamt;
            // multiply codes land here too
            // they are served by the booth unit
            default:  result = 32'hface_beec;
        endcase
    end

endmodule

// File: logic/branch_cond.sv
module branch_cond import ex_pkg::*; (
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    output logic            take
);

    logic signed [xlen-1:0] rs1_s;
    logic signed [xlen-1:0] rs2_s;

    assign rs1_s = rs1;
    assign rs2_s = rs2;

    always_comb begin
        case (funct3)
            3'b000:  take = rs1 == rs2;
            3'b001:  take = rs1 != rs2;
            3'b100:  take = rs1_s < rs2_s;
            3'b101:  take = rs1_s >= rs2_s;
            3'b110:  take = rs1 < rs2;
            3'b111:  take = rs1 >= rs2;
            // 010 and 011 are not branches
            default: take = 1'b0;
        endcase
    end

endmodule

// File: logic/booth_mult.sv
module booth_mult import ex_pkg::*; #(
    parameter int mult_steps = 33
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  alu_func_e            func,
    input  logic [xlen-1:0]      mcand,
    input  logic [xlen-1:0]      mplier,
    input  logic [rob_tag_w-1:0] tag,
    input  logic                 take,
    output logic                 busy,
    output logic                 done,
    output logic [xlen-1:0]      product,
    output logic [rob_tag_w-1:0] product_tag
);

    // one extra bit so signed and unsigned share one datapath
    localparam int ext_w = xlen + 1;
    localparam int cnt_w = $clog2(mult_steps + 1);
    localparam logic [cnt_w-1:0] last_step = cnt_w'(mult_steps);

    typedef enum logic [1:0] {st_idle, st_run, st_done} state_e;

    state_e           state;
    logic [cnt_w-1:0] step_cnt;
    alu_func_e        func_q;
    logic [ext_w:0]   m_q;
    logic [ext_w:0]   acc_q;
    logic [ext_w-1:0] mq_q;
    logic             q_m1;
    logic             mcand_signed;
    logic             mplier_signed;
    logic [ext_w-1:0] mcand_ext;
    logic [ext_w-1:0] mplier_ext;
    logic [ext_w:0]   acc_sum;
    logic [2*ext_w:0] full_prod;

    //////////////////////////////////////////////////
    // operand extension
    //////////////////////////////////////////////////
    // mulhsu: rs1 signed, rs2 unsigned
    assign mcand_signed  = func inside {alu_mul, alu_mulh, alu_mulhsu};
    assign mplier_signed = func inside {alu_mul, alu_mulh};
    assign mcand_ext     = {mcand_signed & mcand[xlen-1], mcand};
    assign mplier_ext    = {mplier_signed & mplier[xlen-1], mplier};

    // booth recode on the pair {q0, q-1}
    always_comb begin
        case ({mq_q[0], q_m1})
            2'b01:   acc_sum = acc_q + m_q;
            2'b10:   acc_sum = acc_q - m_q;
            default: acc_sum = acc_q;
        endcase
    end

    assign full_prod = {acc_q, mq_q};

    //////////////////////////////////////////////////
    // control fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_run;
                        step_cnt <= '0;
                    end
                end
                st_run: begin
                    // extra cycle after the last step picks the half
                    if (step_cnt == last_step) begin
                        state <= st_done;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                st_done: begin
                    if (take) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            func_q      <= func;
            product_tag <= tag;
            m_q         <= {mcand_ext[ext_w-1], mcand_ext};
            acc_q       <= '0;
            mq_q        <= mplier_ext;
            q_m1        <= 1'b0;
        end else if (state == st_run) begin
            if (step_cnt == last_step) begin
                product <= (func_q == alu_mul) ? full_prod[xlen-1:0]
                                               : full_prod[2*xlen-1:xlen];
            end else begin
                // add or subtract, then arithmetic shift right by one
                {acc_q, mq_q, q_m1} <= {acc_sum[ext_w], acc_sum, mq_q};
            end
        end
    end

    assign busy = state != st_idle;
    assign done = state == st_done;

    // issue must hold back a second multiply until this one is taken
    assert property (@(posedge clk) disable iff (rst) start |-> !busy && is_mul_func(func))
        else $error("multiply started while the multiplier is busy");
    assert property (@(posedge clk) disable iff (rst) take |-> done)
        else $error("multiply result taken before it was done");

endmodule

// File: logic/stage_ex.sv
module stage_ex import ex_pkg::*; #(
    parameter int mult_steps = 33
) (
    input  logic              clk,
    input  logic              rst,
    input  is_ex_packet_t     issue_pkt,
    input  logic              cdb_busy,
    output logic              issue_ready,
    output logic              mult_busy,
    output logic              take_conditional,
    output ex_cp_packet_t     cp_pkt,
    output priv_addr_packet_t addr_pkt
);

    logic [xlen-1:0]      opa_val;
    logic [xlen-1:0]      opb_val;
    logic [xlen-1:0]      alu_result;
    logic [xlen-1:0]      mem_addr;
    logic [xlen-1:0]      mult_product;
    logic [rob_tag_w-1:0] mult_tag;
    logic                 mult_done;
    logic                 mult_start;
    logic                 mult_take;
    logic                 is_mem;
    logic                 is_mul;
    logic                 is_simple;
    logic                 cp_hold;
    logic                 accept;
    logic                 take_branch;
    ex_cp_packet_t        alu_cp;
    ex_cp_packet_t        mult_cp;

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    operand_select operand_select_i (
        .issue_pkt (issue_pkt),
        .opa_val   (opa_val),
        .opb_val   (opb_val)
    );

    ex_alu ex_alu_i (
        .opa    (opa_val),
        .opb    (opb_val),
        .func   (issue_pkt.alu_func),
        .result (alu_result)
    );

    // compares raw register values, not the muxed operands
    branch_cond branch_cond_i (
        .funct3 (issue_pkt.inst[14:12]),
        .rs1    (issue_pkt.opa),
        .rs2    (issue_pkt.opb),
        .take   (take_conditional)
    );

    booth_mult #(
        .mult_steps (mult_steps)
    ) booth_mult_i (
        .clk         (clk),
        .rst         (rst),
        .start       (mult_start),
        .func        (issue_pkt.alu_func),
        .mcand       (opa_val),
        .mplier      (opb_val),
        .tag         (issue_pkt.rob_tag),
        .take        (mult_take),
        .busy        (mult_busy),
        .done        (mult_done),
        .product     (mult_product),
        .product_tag (mult_tag)
    );

    //////////////////////////////////////////////////
    // classify and accept
    //////////////////////////////////////////////////
    assign is_mem    = issue_pkt.rd_mem | issue_pkt.wr_mem;
    assign is_mul    = is_mul_func(issue_pkt.alu_func) && !is_mem;
    assign is_simple = !is_mem && !is_mul;

    // bus still owns the current completion
    assign cp_hold = cp_pkt.valid && cdb_busy;

    // waiting multiply result blocks new simple work
    assign issue_ready = is_mem || !(cp_hold || mult_done || (is_mul && mult_busy));
    assign accept      = issue_pkt.issue_valid && issue_ready;
    assign mult_start  = accept && is_mul;
    assign mult_take   = mult_done && !cp_hold;

    // completion value
    assign take_branch = issue_pkt.uncond_branch || (issue_pkt.cond_branch && take_conditional);
    assign mem_addr    = opa_val + opb_val;

    always_comb begin
        alu_cp.valid       = 1'b1;
        alu_cp.rob_tag     = issue_pkt.rob_tag;
        alu_cp.take_branch = take_branch;
        // not-taken conditional falls through to npc
        if (issue_pkt.cond_branch && !issue_pkt.uncond_branch && !take_conditional) begin
            alu_cp.value = issue_pkt.npc;
        end else begin
            alu_cp.value = alu_result;
        end
    end

    assign mult_cp.valid       = 1'b1;
    assign mult_cp.rob_tag     = mult_tag;
    assign mult_cp.value       = mult_product;
    assign mult_cp.take_branch = 1'b0;

    //////////////////////////////////////////////////
    // completion and address registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cp_pkt <= '0;
        end else if (!cp_hold) begin
            // multiplier result has priority
            if (mult_done) begin
                cp_pkt <= mult_cp;
            end else if (accept && is_simple) begin
                cp_pkt <= alu_cp;
            end else begin
                cp_pkt.valid <= 1'b0;
            end
        end
    end

    // loads and stores bypass the bus entirely
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_pkt <= '0;
        end else begin
            addr_pkt.valid <= accept && is_mem;
            addr_pkt.tag   <= issue_pkt.rob_tag;
            addr_pkt.addr  <= mem_addr;
        end
    end

    // bus sees a frozen packet for as long as it is busy
    assert property (@(posedge clk) disable iff (rst) cp_pkt.valid && cdb_busy |=> $stable(cp_pkt))
        else $error("completion packet changed while cdb_busy was high");

endmodule

// File: testbench/stage_ex_tb.sv
module stage_ex_tb import ex_pkg::*; ();

    localparam int clk_period = 100;
    localparam int mult_steps = 33;
    // accept to cp_pkt plus some slack
    localparam int mult_lat   = mult_steps + 6;
    // upper bound on packets over all tests
    localparam int max_ops    = 420;
    localparam longint watchdog_limit = longint'(max_ops) * mult_lat * clk_period;

    localparam logic [31:0] br_a [6] = '{32'd5, 32'd3, 32'd9, 32'hffff_fffe, 32'd4,
                                         32'h8000_0000};
    localparam logic [31:0] br_b [6] = '{32'd5, 32'd9, 32'd3, 32'd4, 32'hffff_fffe,
                                         32'h7fff_ffff};
    localparam logic [2:0]  br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam logic [31:0] corner [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h1};

    logic              clk;
    logic              rst;
    is_ex_packet_t     issue_pkt;
    logic              cdb_busy;
    logic              issue_ready;
    logic              mult_busy;
    logic              take_conditional;
    ex_cp_packet_t     cp_pkt;
    priv_addr_packet_t addr_pkt;
    integer            seed = 32'h420f_8aef;

    // completion log indexed by rob tag
    int          cp_count   [32];
    logic [31:0] cp_val     [32];
    int          addr_count [32];
    logic [31:0] addr_val   [32];
    int          cp_total;
    logic        exp_used   [32];
    logic        exp_mem    [32];
    logic [31:0] exp_val    [32];
    int          exp_cp;

    stage_ex #(
        .mult_steps (mult_steps)
    ) dut_i (
        .clk              (clk),
        .rst              (rst),
        .issue_pkt        (issue_pkt),
        .cdb_busy         (cdb_busy),
        .issue_ready      (issue_ready),
        .mult_busy        (mult_busy),
        .take_conditional (take_conditional),
        .cp_pkt           (cp_pkt),
        .addr_pkt         (addr_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_limit);
        $display("Watchdog: run did not finish within %0d time units", watchdog_limit);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    // sampled mid cycle when cdb_busy has settled for the next edge
    always @(negedge clk) begin
        if (!rst && cp_pkt.valid && !cdb_busy) begin
            cp_count[cp_pkt.rob_tag] = cp_count[cp_pkt.rob_tag] + 1;
            cp_val[cp_pkt.rob_tag]   = cp_pkt.value;
            cp_total                 = cp_total + 1;
        end
        if (!rst && addr_pkt.valid) begin
            addr_count[addr_pkt.tag] = addr_count[addr_pkt.tag] + 1;
            addr_val[addr_pkt.tag]   = addr_pkt.addr;
        end
    end

    //////////////////////////////////////////////////
    // reference models
    //////////////////////////////////////////////////
    // fill everything above bit msb with bit msb
    function automatic logic [31:0] sext(input logic [31:0] v, input int msb);
        logic [31:0] mask;
        mask = 32'hffff_ffff << msb;
        return v[msb] ? (v | mask) : (v & ~mask);
    endfunction

    function automatic logic [31:0] opa_model(input is_ex_packet_t p);
        case (p.opa_select)
            opa_is_rs1: return p.opa;
            opa_is_npc: return p.npc;
            opa_is_pc:  return p.pc;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] opb_model(input is_ex_packet_t p);
        logic [31:0] i;
        i = p.inst;
        case (p.opb_select)
            opb_is_rs2:   return p.opb;
            opb_is_i_imm: return sext({20'b0, i[31:20]}, 11);
            opb_is_s_imm: return sext({20'b0, i[31:25], i[11:7]}, 11);
            opb_is_b_imm: return sext({19'b0, i[31], i[7], i[30:25], i[11:8], 1'b0}, 12);
            opb_is_u_imm: return {i[31:12], 12'h000};
            default:      return sext({11'b0, i[31], i[19:12], i[20], i[30:21], 1'b0}, 20);
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input alu_func_e f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return 32'($signed(a) >>> b[4:0]);
            default:  return 32'h0;
        endcase
    endfunction

    // full 64 bit product then pick the half
    function automatic logic [31:0] mul_model(input alu_func_e f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea   = (f == alu_mulhu) ? {32'h0, a} : {{32{a[31]}}, a};
        eb   = (f == alu_mul || f == alu_mulh) ? {{32{b[31]}}, b} : {32'h0, b};
        prod = ea * eb;
        return (f == alu_mul) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail time %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_cp(input logic [4:0] tag, input logic [31:0] value,
                            input logic take);
        check_val("cp_pkt.valid", 32'd1, 32'(cp_pkt.valid));
        check_val("cp_pkt.rob_tag", 32'(tag), 32'(cp_pkt.rob_tag));
        check_val("cp_pkt.value", value, cp_pkt.value);
        check_val("cp_pkt.take_branch", 32'(take), 32'(cp_pkt.take_branch));
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    // random fields with rs1 and rs2 sources and no control flags
    task automatic new_pkt(output is_ex_packet_t p, input logic [4:0] tag,
                           input alu_func_e f);
        p             = '0;
        p.issue_valid = 1'b1;
        p.rob_tag     = tag;
        p.pc          = $random(seed) & 32'hffff_fffc;
        p.npc         = p.pc + 32'd4;
        p.inst        = $random(seed);
        p.opa         = $random(seed);
        p.opb         = $random(seed);
        p.alu_func    = f;
    endtask

    // starts and ends 10 units after an edge
    // tc is take_conditional seen just before acceptance
    task automatic send(input is_ex_packet_t p, output logic tc);
        int waited;
        waited    = 0;
        issue_pkt = p;
        #40;
        while (!issue_ready) begin
            waited++;
            if (waited > 2 * mult_lat) begin
                timeout_fail($sformatf("issue_ready stayed low for tag %0d", p.rob_tag));
            end
            @(posedge clk);
            #50;
        end
        tc = take_conditional;
        @(posedge clk);
        #10;
        issue_pkt.issue_valid = 1'b0;
    endtask

    task automatic wait_tag(input logic [4:0] tag);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(cp_pkt.valid && cp_pkt.rob_tag == tag)) begin
            cycles++;
            if (cycles > mult_lat) begin
                timeout_fail($sformatf("multiply with tag %0d never completed", tag));
            end
            @(negedge clk);
        end
    endtask

    task automatic clear_log();
        for (int t = 0; t < 32; t++) begin
            cp_count[t]   = 0;
            addr_count[t] = 0;
            exp_used[t]   = 1'b0;
            exp_mem[t]    = 1'b0;
        end
        cp_total = 0;
        exp_cp   = 0;
    endtask

    // expected outcome of one packet of the overlap test
    task automatic note(input is_ex_packet_t p);
        logic [31:0] a;
        logic [31:0] b;
        a                   = opa_model(p);
        b                   = opb_model(p);
        exp_used[p.rob_tag] = 1'b1;
        exp_mem[p.rob_tag]  = p.rd_mem | p.wr_mem;
        if (p.rd_mem || p.wr_mem) begin
            exp_val[p.rob_tag] = a + b;
        end else if (p.alu_func inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu}) begin
            exp_val[p.rob_tag] = mul_model(p.alu_func, a, b);
            exp_cp++;
        end else begin
            exp_val[p.rob_tag] = alu_model(p.alu_func, a, b);
            exp_cp++;
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_alu();
        is_ex_packet_t p;
        logic          tc;
        logic [31:0]   exp;
        logic [4:0]    tag;
        tag = 5'd0;
        for (int f = 0; f < 10; f++) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 6; b++) begin
                    new_pkt(p, tag, alu_func_e'(f));
                    p.opa_select = opa_sel_e'(a);
                    p.opb_select = opb_sel_e'(b);
                    exp = alu_model(p.alu_func, opa_model(p), opb_model(p));
                    send(p, tc);
                    check_cp(tag, exp, 1'b0);
                    tag = tag + 5'd1;
                end
            end
        end
    endtask

    task automatic test_branch();
        is_ex_packet_t p;
        logic          tc;
        logic          cond;
        logic [31:0]   exp;
        logic [4:0]    tag;
        tag = 5'd3;
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 6; k++) begin
                new_pkt(p, tag, alu_add);
                p.cond_branch    = 1'b1;
                p.opa_select     = opa_is_pc;
                p.opb_select     = opb_is_b_imm;
                p.opa            = br_a[k];
                p.opb            = br_b[k];
                p.inst[14:12]    = br_f3[c];
                cond = branch_model(br_f3[c], br_a[k], br_b[k]);
                // taken goes to the target and not taken falls through to npc
                exp  = cond ? p.pc + opb_model(p) : p.npc;
                send(p, tc);
                check_val("take_conditional", 32'(cond), 32'(tc));
                check_cp(tag, exp, cond);
                tag = tag + 5'd1;
            end
        end
        // jal
        new_pkt(p, tag, alu_add);
        p.uncond_branch = 1'b1;
        p.opa_select    = opa_is_pc;
        p.opb_select    = opb_is_j_imm;
        exp = p.pc + opb_model(p);
        send(p, tc);
        check_cp(tag, exp, 1'b1);
    endtask

    task automatic test_mult();
        is_ex_packet_t p;
        logic          tc;
        logic [31:0]   exp;
        logic [4:0]    tag;
        tag = 5'd7;
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    new_pkt(p, tag, alu_func_e'(10 + f));
                    // index 4 keeps the random operand
                    if (i < 4) begin
                        p.opa = corner[i];
                    end
                    if (j < 4) begin
                        p.opb = corner[j];
                    end
                    exp = mul_model(p.alu_func, p.opa, p.opb);
                    send(p, tc);
                    wait_tag(tag);
                    check_cp(tag, exp, 1'b0);
                    tick();
                    tag = tag + 5'd1;
                end
            end
        end
    endtask

    task automatic test_backpressure();
        is_ex_packet_t p;
        is_ex_packet_t q;
        logic          tc;
        new_pkt(p, 5'd20, alu_xor);
        new_pkt(q, 5'd21, alu_sub);
        send(p, tc);
        check_cp(5'd20, p.opa ^ p.opb, 1'b0);
        // bus stalls with p still on cp_pkt
        cdb_busy  = 1'b1;
        issue_pkt = q;
        repeat (5) begin
            #40;
            check_cp(5'd20, p.opa ^ p.opb, 1'b0);
            check_val("issue_ready", 32'd0, 32'(issue_ready));
            tick();
        end
        cdb_busy = 1'b0;
        send(q, tc);
        check_cp(5'd21, q.opa - q.opb, 1'b0);
    endtask

    task automatic test_overlap();
        is_ex_packet_t p;
        logic          tc;
        int            waited;
        // let the last back-pressure completion drain before logging
        tick();
        clear_log();
        new_pkt(p, 5'd1, alu_mulh);
        note(p);
        send(p, tc);
        check_val("mult_busy", 32'd1, 32'(mult_busy));
        // simple, load and store while the multiplier runs
        for (int k = 0; k < 16; k++) begin
            if (k == 10) begin
                // second multiply must wait for the first
                new_pkt(p, 5'd12, alu_mulhsu);
                note(p);
                issue_pkt = p;
                waited    = 0;
                #40;
                check_val("mult_busy", 32'd1, 32'(mult_busy));
                while (mult_busy) begin
                    check_val("issue_ready", 32'd0, 32'(issue_ready));
                    waited++;
                    if (waited > 2 * mult_lat) begin
                        timeout_fail("first multiply never released the multiplier");
                    end
                    @(posedge clk);
                    #40;
                end
                check_val("issue_ready", 32'd1, 32'(issue_ready));
                tick();
                issue_pkt.issue_valid = 1'b0;
            end else begin
                new_pkt(p, 5'(2 + k), alu_func_e'(k % 10));
                if (k % 3 == 1) begin
                    p.rd_mem     = 1'b1;
                    p.alu_func   = alu_add;
                    p.opb_select = opb_is_i_imm;
                end else if (k % 3 == 2) begin
                    p.wr_mem     = 1'b1;
                    p.alu_func   = alu_add;
                    p.opb_select = opb_is_s_imm;
                end
                note(p);
                send(p, tc);
            end
        end
        waited = 0;
        while (cp_total < exp_cp) begin
            waited++;
            if (waited > 4 * mult_lat) begin
                timeout_fail("overlap test completions did not all arrive");
            end
            tick();
        end
        // room for a stray repeat
        repeat (3) tick();
        for (int t = 0; t < 32; t++) begin
            if (exp_used[t] && exp_mem[t]) begin
                check_val($sformatf("cp_pkt count tag %0d", t), 32'd0, 32'(cp_count[t]));
                check_val($sformatf("addr_pkt count tag %0d", t), 32'd1, 32'(addr_count[t]));
                check_val($sformatf("addr_pkt.addr tag %0d", t), exp_val[t], addr_val[t]);
            end else if (exp_used[t]) begin
                check_val($sformatf("cp_pkt count tag %0d", t), 32'd1, 32'(cp_count[t]));
                check_val($sformatf("addr_pkt count tag %0d", t), 32'd0, 32'(addr_count[t]));
                check_val($sformatf("cp_pkt.value tag %0d", t), exp_val[t], cp_val[t]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        cdb_busy  = 1'b0;
        issue_pkt = '0;
        clear_log();
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        check_val("cp_pkt.valid", 32'd0, 32'(cp_pkt.valid));
        check_val("addr_pkt.valid", 32'd0, 32'(addr_pkt.valid));
        check_val("mult_busy", 32'd0, 32'(mult_busy));
        check_val("issue_ready", 32'd1, 32'(issue_ready));
        test_alu();
        test_branch();
        test_mult();
        test_backpressure();
        test_overlap();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: stage_ex.f
logic/ex_pkg.sv
logic/operand_select.sv
logic/ex_alu.sv
logic/branch_cond.sv
logic/booth_mult.sv
logic/stage_ex.sv
testbench/stage_ex_tb.sv

// File: Makefile
# verilator build of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= stage_ex_tb
FLIST     ?= stage_ex.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a $fatal in the testbench gives a nonzero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
